//--- Makefile
# Verilator build and run of the convolution tile testbench

VERILATOR ?= verilator
TOP       ?= conv_pe_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/conv_pe_sva.sv
// bound concurrent assertions on the convolution tile top-level ports
`timescale 1ns/1ps
`include "pe_cfg.svh"

module conv_pe_sva (
	input logic         i_clk,
	input logic         i_rst,
	input logic         i_valid,
	input pe_pkg::rot_t i_wgt_shift,
	input logic         o_valid
);

	// o_valid clears in the cycle after a reset edge
	a_reset_clears_valid: assert property (@(posedge i_clk) i_rst |=> !o_valid)
		else $error("o_valid high in the cycle after reset");

	// two-stage valid pipeline, once reset has left both stages
	a_valid_latency: assert property (@(posedge i_clk)
		(!$past(i_rst) && !$past(i_rst, 2)) |-> (o_valid == $past(i_valid, 2)))
		else $error("o_valid does not follow i_valid two cycles later");

	a_shift_range: assert property (@(posedge i_clk) disable iff (i_rst)
		i_valid |-> (int'(i_wgt_shift) < `PE_DIM))
		else $error("i_wgt_shift out of range with i_valid high");

endmodule

bind conv_pe_top conv_pe_sva u_sva (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_valid     (i_valid),
	.i_wgt_shift (i_wgt_shift),
	.o_valid     (o_valid)
);

//--- bench/conv_pe_tb.sv
// testbench for the convolution tile: clock, reset, LFSR stimulus, reference model and checks
`timescale 1ns/1ps
`include "pe_cfg.svh"

module conv_pe_tb;

	import pe_pkg::*;

	localparam int DIM        = `PE_DIM;
	localparam int CLK_NS     = 4;
	localparam int RST_CYCLES = 8;
	localparam int N_RAND     = 48;
	localparam int N_B2B      = 40;
	localparam int MAX_GAP    = 3;
	localparam int DRAIN_MAX  = 8;
	localparam int MARGIN     = 50;
	// two resets, idle, patches after reset, three weight loads, random sweep, bias,
	// clamp, back-to-back and drains
	localparam int STIM_CYCLES = 2 * RST_CYCLES + 6 + 3 * DIM + N_RAND + 4 + 32
		+ N_B2B * (1 + MAX_GAP) + 6 * (DRAIN_MAX + 1);

	typedef struct packed {
		logic [`PE_DATA_W-1:0] r0;
		logic [`PE_DATA_W-1:0] r1;
		logic [31:0]           cyc;
	} exp_t;

	logic                     i_clk;
	logic                     i_rst;
	logic                     i_wgt_wr_en;
	rot_t                     i_wgt_wr_row;
	pixel_t [DIM-1:0]         i_wgt_wr_data;
	logic                     i_bias_wr_en;
	pixel_t                   i_bias;
	logic                     i_valid;
	pixel_t [DIM*DIM-1:0]     i_img;
	rot_t                     i_wgt_shift;
	pshift_t                  i_psum_shift;
	logic                     o_valid;
	pixel_t                   o_result0;
	pixel_t                   o_result1;

	// reference state
	pixel_t      model_w [DIM][DIM];
	pixel_t      model_bias;
	exp_t        exp_q[$];
	int          cycle_cnt;
	int          value_errs;
	int          protocol_errs;
	logic [31:0] lfsr_state = 32'he5003cb9;

	conv_pe_top uut (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_wgt_wr_en   (i_wgt_wr_en),
		.i_wgt_wr_row  (i_wgt_wr_row),
		.i_wgt_wr_data (i_wgt_wr_data),
		.i_bias_wr_en  (i_bias_wr_en),
		.i_bias        (i_bias),
		.i_valid       (i_valid),
		.i_img         (i_img),
		.i_wgt_shift   (i_wgt_shift),
		.i_psum_shift  (i_psum_shift),
		.o_valid       (o_valid),
		.o_result0     (o_result0),
		.o_result1     (o_result1)
	);

	initial i_clk = 1'b0;
	always #2 i_clk = ~i_clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int rand_rot();
		return int'(rand_bits(8)) % DIM;
	endfunction

	function automatic pixel_t clamp8(input int v);
		if (v > 127) begin
			return pixel_t'(127);
		end else if (v < -128) begin
			return pixel_t'(-128);
		end
		return pixel_t'(v);
	endfunction

	// expected results for the patch on the inputs right now
	task automatic model_patch();
		int   s;
		int   p;
		int   col;
		int   acc0;
		int   acc1;
		exp_t e;
		s    = int'(i_wgt_shift);
		p    = int'(i_psum_shift);
		acc0 = 0;
		acc1 = int'(model_bias);
		for (int c = 0; c < DIM; c++) begin
			col = 0;
			for (int r = 0; r < DIM; r++) begin
				col += int'(i_img[c*DIM+r]) * int'(model_w[r][(c - s + DIM) % DIM]);
			end
			if (c < s) begin
				acc0 += col;
			end else begin
				acc1 += col;
			end
		end
		e.r0  = clamp8(acc0 >>> p);
		e.r1  = clamp8(acc1 >>> p);
		e.cyc = cycle_cnt + 2;
		exp_q.push_back(e);
	endtask

	// a patch sees the old weights and bias and writes land afterwards
	task automatic model_step();
		if (i_rst) begin
			// results still in the pipeline are lost at a reset edge
			while (exp_q.size() != 0 && exp_q[$].cyc > cycle_cnt) begin
				void'(exp_q.pop_back());
			end
			model_bias = '0;
			for (int r = 0; r < DIM; r++) begin
				for (int k = 0; k < DIM; k++) begin
					model_w[r][k] = '0;
				end
			end
		end else begin
			if (i_valid) begin
				model_patch();
			end
			if (i_wgt_wr_en && int'(i_wgt_wr_row) < DIM) begin
				for (int k = 0; k < DIM; k++) begin
					model_w[i_wgt_wr_row][k] = i_wgt_wr_data[k];
				end
			end
			if (i_bias_wr_en) begin
				model_bias = i_bias;
			end
		end
	endtask

	task automatic check_outputs();
		exp_t e;
		if (exp_q.size() != 0) begin
			assert (exp_q[0].cyc >= cycle_cnt) else begin
				protocol_errs++;
				$display("no result pair at cycle %0d where one was due", exp_q[0].cyc);
				void'(exp_q.pop_front());
			end
		end
		if (o_valid) begin
			assert (exp_q.size() != 0) else begin
				protocol_errs++;
				$display("o_valid high at cycle %0d with no patch outstanding", cycle_cnt);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (e.cyc == cycle_cnt) else begin
					protocol_errs++;
					$display("result pair came at cycle %0d instead of %0d", cycle_cnt, e.cyc);
				end
				assert (o_result0 === pixel_t'(e.r0)) else begin
					value_errs++;
					$display("FAIL o_result0 expected %h got %h", e.r0, o_result0);
				end
				assert (o_result1 === pixel_t'(e.r1)) else begin
					value_errs++;
					$display("FAIL o_result1 expected %h got %h", e.r1, o_result1);
				end
			end
		end
	endtask

	task automatic end_cycle();
		model_step();
		@(negedge i_clk);
		cycle_cnt++;
		check_outputs();
	endtask

	task automatic clear_strobes();
		i_wgt_wr_en  = 1'b0;
		i_bias_wr_en = 1'b0;
		i_valid      = 1'b0;
	endtask

	task automatic fill_random_img();
		for (int i = 0; i < DIM * DIM; i++) begin
			i_img[i] = pixel_t'(rand_bits(8));
		end
	endtask

	task automatic set_random_row_write();
		i_wgt_wr_en  = 1'b1;
		i_wgt_wr_row = rot_t'(rand_rot());
		for (int k = 0; k < DIM; k++) begin
			i_wgt_wr_data[k] = pixel_t'(rand_bits(8));
		end
	endtask

	// caller sets pixels and any writes first
	task automatic drive_patch(input int s, input int p);
		i_valid      = 1'b1;
		i_wgt_shift  = rot_t'(s);
		i_psum_shift = pshift_t'(p);
		end_cycle();
	endtask

	task automatic load_random_weights();
		for (int r = 0; r < DIM; r++) begin
			clear_strobes();
			set_random_row_write();
			i_wgt_wr_row = rot_t'(r);
			end_cycle();
		end
	endtask

	task automatic load_const_weights(input pixel_t v);
		for (int r = 0; r < DIM; r++) begin
			clear_strobes();
			i_wgt_wr_en  = 1'b1;
			i_wgt_wr_row = rot_t'(r);
			for (int k = 0; k < DIM; k++) begin
				i_wgt_wr_data[k] = v;
			end
			end_cycle();
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		clear_strobes();
		while (exp_q.size() != 0 && n < DRAIN_MAX) begin
			end_cycle();
			n++;
		end
		end_cycle();
	endtask

	// watchdog
	initial begin
		#((STIM_CYCLES + MARGIN) * CLK_NS);
		$display("timeout after %0d cycles, the run did not finish", STIM_CYCLES + MARGIN);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int gap;
		i_rst         = 1'b1;
		i_wgt_wr_row  = '0;
		i_wgt_wr_data = '0;
		i_bias        = '0;
		i_img         = '0;
		i_wgt_shift   = '0;
		i_psum_shift  = '0;
		clear_strobes();
		cycle_cnt     = 0;
		value_errs    = 0;
		protocol_errs = 0;
		repeat (RST_CYCLES) end_cycle();
		i_rst = 1'b0;

		// quiet after reset, then zero weights and bias give zeros
		repeat (4) end_cycle();
		fill_random_img();
		drive_patch(2, 0);
		drain();

		// rotation and split sweep, no bias
		load_random_weights();
		for (int n = 0; n < N_RAND; n++) begin
			clear_strobes();
			fill_random_img();
			drive_patch(n % DIM, 0);
		end
		drain();

		// bias write with a patch reaches only the next patch
		for (int n = 0; n < 2; n++) begin
			clear_strobes();
			fill_random_img();
			i_bias_wr_en = 1'b1;
			i_bias       = pixel_t'(rand_bits(8));
			drive_patch(3 * n, 0);
			clear_strobes();
			fill_random_img();
			drive_patch(3 * n, 0);
		end
		drain();

		// clamping at both ends, then shifted back into range
		load_const_weights(pixel_t'(100));
		for (int p = 0; p < 16; p++) begin
			clear_strobes();
			i_img = {DIM*DIM{pixel_t'(100)}};
			drive_patch(3, p);
		end
		for (int p = 0; p < 16; p++) begin
			clear_strobes();
			i_img = {DIM*DIM{pixel_t'(-100)}};
			drive_patch(2, p);
		end

		// reset with a patch in flight clears o_valid, weights and bias
		clear_strobes();
		i_rst = 1'b1;
		repeat (RST_CYCLES) end_cycle();
		i_rst = 1'b0;
		fill_random_img();
		drive_patch(3, 0);
		drain();

		// back-to-back patches with gaps and weight rewrites
		load_random_weights();
		for (int n = 0; n < N_B2B; n++) begin
			clear_strobes();
			fill_random_img();
			if (rand_bits(2) == 0) begin
				set_random_row_write();
			end
			drive_patch(rand_rot(), int'(rand_bits(3)));
			gap = rand_bits(1) ? 0 : int'(rand_bits(2));
			repeat (gap) begin
				clear_strobes();
				if (rand_bits(1)) begin
					set_random_row_write();
				end
				end_cycle();
			end
		end
		drain();

		assert (exp_q.size() == 0) else begin
			protocol_errs++;
			$display("%0d result pairs were still outstanding at the end", exp_q.size());
		end
		$display("value errors: %0d, protocol errors: %0d", value_errs, protocol_errs);
		if (value_errs + protocol_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- design/conv_pe_top.sv
// convolution tile top: weight bank, six column MAC units and the psum combiner
`timescale 1ns/1ps
`include "pe_cfg.svh"

module conv_pe_top (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_wgt_wr_en,
	input  pe_pkg::rot_t                          i_wgt_wr_row,
	input  pe_pkg::pixel_t [`PE_DIM-1:0]          i_wgt_wr_data,
	input  logic                                  i_bias_wr_en,
	input  pe_pkg::pixel_t                        i_bias,
	input  logic                                  i_valid,
	input  pe_pkg::pixel_t [`PE_DIM*`PE_DIM-1:0]  i_img,
	input  pe_pkg::rot_t                          i_wgt_shift,
	input  pe_pkg::pshift_t                       i_psum_shift,
	output logic                                  o_valid,
	output pe_pkg::pixel_t                        o_result0,
	output pe_pkg::pixel_t                        o_result1
);

	import pe_pkg::*;

	localparam int DIM = `PE_DIM;

	pixel_t [DIM-1:0][DIM-1:0] wgt_col;
	col_sum_t [DIM-1:0]        col_sum;

	wgt_bank u_wgt_bank (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wr_en     (i_wgt_wr_en),
		.i_wr_row    (i_wgt_wr_row),
		.i_wr_data   (i_wgt_wr_data),
		.i_wgt_shift (i_wgt_shift),
		.o_wgt_col   (wgt_col)
	);

	// pixel column c is i_img[c*6 +: 6]
	genvar gc;
	generate
		for (gc = 0; gc < DIM; gc++) begin : g_mac
			mac_column u_mac (
				.i_clk (i_clk),
				.i_pix (i_img[gc*DIM +: DIM]),
				.i_wgt (wgt_col[gc]),
				.o_sum (col_sum[gc])
			);
		end
	endgenerate

	psum_combine u_psum (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_valid      (i_valid),
		.i_wgt_shift  (i_wgt_shift),
		.i_psum_shift (i_psum_shift),
		.i_bias_wr_en (i_bias_wr_en),
		.i_bias       (i_bias),
		.i_col_sum    (col_sum),
		.o_valid      (o_valid),
		.o_result0    (o_result0),
		.o_result1    (o_result1)
	);

endmodule

//--- design/mac_column.sv
// registered six-term signed dot product of one pixel column and one weight column
`timescale 1ns/1ps
`include "pe_cfg.svh"

module mac_column (
	input  logic                         i_clk,
	input  pe_pkg::pixel_t [`PE_DIM-1:0] i_pix,
	input  pe_pkg::pixel_t [`PE_DIM-1:0] i_wgt,
	output pe_pkg::col_sum_t             o_sum
);

	import pe_pkg::*;

	localparam int DIM    = `PE_DIM;
	localparam int PROD_W = 2 * `PE_DATA_W;

	logic signed [PROD_W-1:0] prod [DIM];
	col_sum_t                 pair [DIM/2];
	col_sum_t                 quad;
	col_sum_t                 sum_next;

	always_comb begin
		for (int k = 0; k < DIM; k++) begin
			prod[k] = $signed(i_pix[k]) * $signed(i_wgt[k]);
		end
	end

	// adder tree, three pairs then two levels
	always_comb begin
		for (int i = 0; i < DIM / 2; i++) begin
			pair[i] = col_sum_t'(prod[2*i]) + col_sum_t'(prod[2*i+1]);
		end
		quad     = pair[0] + pair[1];
		sum_next = quad + pair[2];
	end

	always_ff @(posedge i_clk) begin
		o_sum <= sum_next;
	end

endmodule

//--- design/pe_cfg.svh
// data, array, sum and shift-field width macros for the convolution tile
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// one pixel, weight, bias or result
`define PE_DATA_W 8

// rows and columns of the weight array and the patch
`define PE_DIM 6

// six 16-bit products summed in one column
`define PE_COL_SUM_W 19

// split sum with room for the bias
`define PE_ACC_W 20

// shift fields
`define PE_ROT_W 3
`define PE_PSHIFT_W 4

`endif

//--- design/pe_pkg.sv
// vector types for pixels, column sums, split sums and shift fields
`include "pe_cfg.svh"

package pe_pkg;

	// pixels, weights, bias and results
	typedef logic signed [`PE_DATA_W-1:0] pixel_t;

	// one column dot product
	typedef logic signed [`PE_COL_SUM_W-1:0] col_sum_t;

	// split sum before the output shift
	typedef logic signed [`PE_ACC_W-1:0] acc_t;

	// weight rotation, 0 to 5
	typedef logic [`PE_ROT_W-1:0] rot_t;

	// arithmetic right shift of both sums
	typedef logic [`PE_PSHIFT_W-1:0] pshift_t;

endpackage

//--- design/psum_combine.sv
// bias register, split summing, arithmetic shift, saturation and valid pipeline
`timescale 1ns/1ps
`include "pe_cfg.svh"

module psum_combine (
	input  logic                           i_clk,
	input  logic                           i_rst,
	input  logic                           i_valid,
	input  pe_pkg::rot_t                   i_wgt_shift,
	input  pe_pkg::pshift_t                i_psum_shift,
	input  logic                           i_bias_wr_en,
	input  pe_pkg::pixel_t                 i_bias,
	input  pe_pkg::col_sum_t [`PE_DIM-1:0] i_col_sum,
	output logic                           o_valid,
	output pe_pkg::pixel_t                 o_result0,
	output pe_pkg::pixel_t                 o_result1
);

	import pe_pkg::*;

	localparam int DIM     = `PE_DIM;
	localparam int SAT_MAX = 2 ** (`PE_DATA_W - 1) - 1;
	localparam int SAT_MIN = -(2 ** (`PE_DATA_W - 1));

	pixel_t  bias_q;
	logic    valid_d;
	rot_t    wgt_shift_d;
	pshift_t psum_shift_d;
	pixel_t  bias_d;

	acc_t sum0;
	acc_t sum1;
	acc_t shifted0;
	acc_t shifted1;

	// clamp a shifted sum to the result range
	function automatic pixel_t saturate(input acc_t v);
		if (v > SAT_MAX) begin
			return pixel_t'(SAT_MAX);
		end else if (v < SAT_MIN) begin
			return pixel_t'(SAT_MIN);
		end
		return v[`PE_DATA_W-1:0];
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bias_q <= '0;
		end else if (i_bias_wr_en) begin
			bias_q <= i_bias;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_d <= 1'b0;
		end else begin
			valid_d <= i_valid;
		end
	end

	// controls and bias travel with the patch into the column registers
	// so a bias write in the patch cycle does not reach that patch
	always_ff @(posedge i_clk) begin
		wgt_shift_d  <= i_wgt_shift;
		psum_shift_d <= i_psum_shift;
		bias_d       <= bias_q;
	end

	// columns below the rotation point go to sum0, the rest plus bias to sum1
	always_comb begin
		sum0 = '0;
		sum1 = acc_t'(bias_d);
		for (int c = 0; c < DIM; c++) begin
			if (c < int'(wgt_shift_d)) begin
				sum0 = sum0 + acc_t'(i_col_sum[c]);
			end else begin
				sum1 = sum1 + acc_t'(i_col_sum[c]);
			end
		end
	end

	assign shifted0 = sum0 >>> psum_shift_d;
	assign shifted1 = sum1 >>> psum_shift_d;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= valid_d;
		end
	end

	always_ff @(posedge i_clk) begin
		o_result0 <= saturate(shifted0);
		o_result1 <= saturate(shifted1);
	end

endmodule

//--- design/wgt_bank.sv
// weight register bank with per-row rotation and transposition to columns
`timescale 1ns/1ps
`include "pe_cfg.svh"

module wgt_bank (
	input  logic                                     i_clk,
	input  logic                                     i_rst,
	input  logic                                     i_wr_en,
	input  pe_pkg::rot_t                             i_wr_row,
	input  pe_pkg::pixel_t [`PE_DIM-1:0]             i_wr_data,
	input  pe_pkg::rot_t                             i_wgt_shift,
	output pe_pkg::pixel_t [`PE_DIM-1:0][`PE_DIM-1:0] o_wgt_col
);

	import pe_pkg::*;

	localparam int DIM = `PE_DIM;

	pixel_t [DIM-1:0] wgt_q   [DIM];
	pixel_t [DIM-1:0] rot_row [DIM];

	// position k of a rotated row takes element (k - s) mod 6
	function automatic int src_idx(input int k, input rot_t s);
		return (k + 2 * DIM - int'(s)) % DIM;
	endfunction

	// one row per write, rows 6 and 7 are not stored
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int r = 0; r < DIM; r++) begin
				wgt_q[r] <= '0;
			end
		end else if (i_wr_en && (int'(i_wr_row) < DIM)) begin
			wgt_q[i_wr_row] <= i_wr_data;
		end
	end

	always_comb begin
		for (int r = 0; r < DIM; r++) begin
			for (int k = 0; k < DIM; k++) begin
				rot_row[r][k] = wgt_q[r][src_idx(k, i_wgt_shift)];
			end
		end
	end

	// column c gathers element c of every rotated row
	genvar gc, gr;
	generate
		for (gc = 0; gc < DIM; gc++) begin : g_col
			for (gr = 0; gr < DIM; gr++) begin : g_row
				assign o_wgt_col[gc][gr] = rot_row[gr][gc];
			end
		end
	endgenerate

endmodule

//--- files.f
+incdir+design
design/pe_pkg.sv
design/wgt_bank.sv
design/mac_column.sv
design/psum_combine.sv
design/conv_pe_top.sv
bench/conv_pe_sva.sv
bench/conv_pe_tb.sv
